/* include/slc3_defines.svh */
`ifndef SLC3_DEFINES_SVH
`define SLC3_DEFINES_SVH

// Data path and address width
`define SLC3_WORD 16

// General register file size
`define SLC3_NREGS 8

// Bits needed to index one general register
`define SLC3_REGW 3

// First fetch address out of reset
`define SLC3_RESET_PC 16'h0000

`endif

/* verilog/slc3Pkg.sv */
package slc3Pkg;

    // ------------------------------------------------------------------
    // Opcodes kept from the LC-3 ISA, IR[15:12]
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        opBr  = 4'b0000,
        opAdd = 4'b0001,
        opAnd = 4'b0101,
        opLdr = 4'b0110,
        opStr = 4'b0111,
        opNot = 4'b1001,
        opJmp = 4'b1100,
        // Reserved LC-3 slot reused for pause
        opPse = 4'b1101,
        opLea = 4'b1110
    } opcodeT;

    // ------------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        fetchMar, fetchRead, fetchMdr, fetchIr, decode,
        execAlu, execBr, execJmp, execLea,
        memAddr, memRead, memMdr, memLoad,
        storeMdr, storeWrite, pause
    } ctrlStateT;

    // ------------------------------------------------------------------
    // Datapath mux selects
    // ------------------------------------------------------------------
    // Next PC source
    typedef enum logic [1:0] {pcPlus1, pcAddrSum, pcBus} pcSelT;

    // Address adder, first operand
    typedef enum logic {addr1Pc, addr1Sr1} addr1SelT;

    // Address adder, second operand, sign extended IR fields
    typedef enum logic [1:0] {addr2Zero, addr2Off6, addr2Off9, addr2Off11} addr2SelT;

    // ALU function
    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPassA} aluOpT;

endpackage

/* verilog/regFile.sv */
`timescale 1ns/1ps
`include "slc3_defines.svh"

module regFile (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic [`SLC3_WORD-1:0]  busIn,
    input  logic [`SLC3_REGW-1:0]  wAddr,
    input  logic [`SLC3_REGW-1:0]  rAddrA,
    input  logic [`SLC3_REGW-1:0]  rAddrB,
    input  logic                   ldReg,
    output logic [`SLC3_WORD-1:0]  rDataA,
    output logic [`SLC3_WORD-1:0]  rDataB
);

    logic [`SLC3_WORD-1:0] regs [`SLC3_NREGS];

    // Write from bus, all registers zero after reset
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `SLC3_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ldReg) begin
            regs[wAddr] <= busIn;
        end
    end

    // Combinational reads, SR1 and SR2
    assign rDataA = regs[rAddrA];
    assign rDataB = regs[rAddrB];

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ps
`include "slc3_defines.svh"

module datapath (
    input  logic                   Clk,
    input  logic                   rstN,
    // Register loads
    input  logic                   ldMar,
    input  logic                   ldMdr,
    input  logic                   ldIr,
    input  logic                   ldBen,
    input  logic                   ldCc,
    input  logic                   ldReg,
    input  logic                   ldPc,
    input  logic                   ldLed,
    // Bus gates
    input  logic                   gatePc,
    input  logic                   gateMdr,
    input  logic                   gateAlu,
    input  logic                   gateMarMux,
    // Selects
    input  slc3Pkg::pcSelT         pcSel,
    input  slc3Pkg::addr1SelT      addr1Sel,
    input  slc3Pkg::addr2SelT      addr2Sel,
    input  logic                   sr1Sel,
    input  slc3Pkg::aluOpT         aluOp,
    input  logic                   mioEn,
    input  logic [`SLC3_WORD-1:0]  memRData,
    output logic [`SLC3_WORD-1:0]  ir,
    output logic                   ben,
    output logic [`SLC3_WORD-1:0]  mar,
    output logic [`SLC3_WORD-1:0]  mdr,
    output logic [11:0]            led
);

    import slc3Pkg::*;

    // ------------------------------------------------------------------
    // Internal signals
    // ------------------------------------------------------------------
    logic [`SLC3_WORD-1:0] pc;
    logic [`SLC3_WORD-1:0] pcNext;
    logic [`SLC3_WORD-1:0] bus;
    logic [`SLC3_WORD-1:0] addr1;
    logic [`SLC3_WORD-1:0] addr2;
    logic [`SLC3_WORD-1:0] addrSum;
    logic [`SLC3_WORD-1:0] sr1Data;
    logic [`SLC3_WORD-1:0] sr2Data;
    logic [`SLC3_WORD-1:0] aluB;
    logic [`SLC3_WORD-1:0] aluOut;
    logic [`SLC3_REGW-1:0] sr1Addr;
    logic                  ccN;
    logic                  ccZ;
    logic                  ccP;

    // SR1 is BaseR/SR at IR[8:6], or the STR source at IR[11:9]
    assign sr1Addr = sr1Sel ? ir[11:9] : ir[8:6];

    // DR always IR[11:9], SR2 always IR[2:0]
    regFile regs (
        .Clk    (Clk),
        .rstN   (rstN),
        .busIn  (bus),
        .wAddr  (ir[11:9]),
        .rAddrA (sr1Addr),
        .rAddrB (ir[2:0]),
        .ldReg  (ldReg),
        .rDataA (sr1Data),
        .rDataB (sr2Data)
    );

    // ------------------------------------------------------------------
    // Bus, address adder and ALU
    // ------------------------------------------------------------------
    always_comb begin
        addr1 = (addr1Sel == addr1Sr1) ? sr1Data : pc;

        case (addr2Sel)
            addr2Off6:  addr2 = {{(`SLC3_WORD-6){ir[5]}}, ir[5:0]};
            addr2Off9:  addr2 = {{(`SLC3_WORD-9){ir[8]}}, ir[8:0]};
            addr2Off11: addr2 = {{(`SLC3_WORD-11){ir[10]}}, ir[10:0]};
            default:    addr2 = '0;
        endcase

        addrSum = addr1 + addr2;

        // Immediate form when IR[5] set
        aluB = ir[5] ? {{(`SLC3_WORD-5){ir[4]}}, ir[4:0]} : sr2Data;

        case (aluOp)
            aluAdd:  aluOut = sr1Data + aluB;
            aluAnd:  aluOut = sr1Data & aluB;
            aluNot:  aluOut = ~sr1Data;
            default: aluOut = sr1Data;
        endcase

        // Single gate drives the bus, idle bus reads zero
        case ({gatePc, gateMdr, gateAlu, gateMarMux})
            4'b1000: bus = pc;
            4'b0100: bus = mdr;
            4'b0010: bus = aluOut;
            4'b0001: bus = addrSum;
            default: bus = '0;
        endcase

        case (pcSel)
            pcAddrSum: pcNext = addrSum;
            pcBus:     pcNext = bus;
            default:   pcNext = pc + 1'b1;
        endcase
    end

    // ------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc  <= `SLC3_RESET_PC;
            ir  <= '0;
            ben <= 1'b0;
            led <= '0;
            // Z set to match the all-zero register file
            ccN <= 1'b0;
            ccZ <= 1'b1;
            ccP <= 1'b0;
        end else begin
            if (ldPc) begin
                pc <= pcNext;
            end
            if (ldIr) begin
                ir <= bus;
            end
            // Sign from bus bit 15
            if (ldCc) begin
                ccN <= bus[`SLC3_WORD-1];
                ccZ <= (bus == '0);
                ccP <= !bus[`SLC3_WORD-1] && (bus != '0);
            end
            if (ldBen) begin
                ben <= (ir[11] & ccN) | (ir[10] & ccZ) | (ir[9] & ccP);
            end
            if (ldLed) begin
                led <= ir[11:0];
            end
        end
    end

    // Memory address and data, no reset
    always_ff @(posedge Clk) begin
        if (ldMar) begin
            mar <= bus;
        end
        if (ldMdr) begin
            mdr <= mioEn ? memRData : bus;
        end
    end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
`include "slc3_defines.svh"

module controlUnit (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic [`SLC3_WORD-1:0]  ir,
    input  logic                   ben,
    output logic                   ldMar,
    output logic                   ldMdr,
    output logic                   ldIr,
    output logic                   ldBen,
    output logic                   ldCc,
    output logic                   ldReg,
    output logic                   ldPc,
    output logic                   ldLed,
    output logic                   gatePc,
    output logic                   gateMdr,
    output logic                   gateAlu,
    output logic                   gateMarMux,
    output slc3Pkg::pcSelT         pcSel,
    output slc3Pkg::addr1SelT      addr1Sel,
    output slc3Pkg::addr2SelT      addr2Sel,
    output logic                   sr1Sel,
    output slc3Pkg::aluOpT         aluOp,
    output logic                   mioEn,
    output logic                   memRe,
    output logic                   memWe,
    output logic                   halted
);

    import slc3Pkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    opcodeT    opcode;

    assign opcode = opcodeT'(ir[15:12]);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= fetchMar;
        end else begin
            state <= stateNext;
        end
    end

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        case (state)
            fetchMar:  stateNext = fetchRead;
            fetchRead: stateNext = fetchMdr;
            fetchMdr:  stateNext = fetchIr;
            fetchIr:   stateNext = decode;
            decode: begin
                case (opcode)
                    opAdd, opAnd, opNot: stateNext = execAlu;
                    opBr:                stateNext = execBr;
                    opJmp:               stateNext = execJmp;
                    opLea:               stateNext = execLea;
                    opLdr, opStr:        stateNext = memAddr;
                    opPse:               stateNext = pause;
                    // Unsupported opcodes act as no-ops
                    default:             stateNext = fetchMar;
                endcase
            end
            memAddr:    stateNext = (opcode == opStr) ? storeMdr : memRead;
            memRead:    stateNext = memMdr;
            memMdr:     stateNext = memLoad;
            storeMdr:   stateNext = storeWrite;
            // Only reset leaves pause
            pause:      stateNext = pause;
            default:    stateNext = fetchMar;
        endcase
    end

    // ------------------------------------------------------------------
    // Strobes per state
    // ------------------------------------------------------------------
    always_comb begin
        {ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed} = '0;
        {gatePc, gateMdr, gateAlu, gateMarMux} = '0;
        pcSel    = pcPlus1;
        addr1Sel = addr1Pc;
        addr2Sel = addr2Zero;
        sr1Sel   = 1'b0;
        aluOp    = aluPassA;
        {mioEn, memRe, memWe} = '0;
        case (state)
            // MAR <- PC, PC <- PC + 1
            fetchMar: begin
                gatePc = 1'b1;
                ldMar  = 1'b1;
                ldPc   = 1'b1;
            end
            fetchRead: memRe = 1'b1;
            // Read data lands one cycle after memRe
            fetchMdr, memMdr: begin
                mioEn = 1'b1;
                ldMdr = 1'b1;
            end
            fetchIr: begin
                gateMdr = 1'b1;
                ldIr    = 1'b1;
            end
            decode: ldBen = 1'b1;
            execAlu: begin
                gateAlu = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
                case (opcode)
                    opAnd:   aluOp = aluAnd;
                    opNot:   aluOp = aluNot;
                    default: aluOp = aluAdd;
                endcase
            end
            // PC <- PC + off9 when nzp matched
            execBr: begin
                pcSel    = pcAddrSum;
                addr2Sel = addr2Off9;
                ldPc     = ben;
            end
            // BaseR passes through the ALU onto the bus
            execJmp: begin
                gateAlu = 1'b1;
                pcSel   = pcBus;
                ldPc    = 1'b1;
            end
            // LEA updates CC as on the classic LC-3
            execLea: begin
                addr2Sel   = addr2Off9;
                gateMarMux = 1'b1;
                ldReg      = 1'b1;
                ldCc       = 1'b1;
            end
            // MAR <- BaseR + off6
            memAddr: begin
                addr1Sel   = addr1Sr1;
                addr2Sel   = addr2Off6;
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            memRead: memRe = 1'b1;
            memLoad: begin
                gateMdr = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
            end
            // Source register at IR[11:9] into MDR
            storeMdr: begin
                sr1Sel  = 1'b1;
                gateAlu = 1'b1;
                ldMdr   = 1'b1;
            end
            storeWrite: memWe = 1'b1;
            pause:      ldLed = 1'b1;
            default: ;
        endcase
    end

    assign halted = (state == pause);

endmodule

/* verilog/slc3Top.sv */
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3Top (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic [`SLC3_WORD-1:0]  memRData,
    output logic [`SLC3_WORD-1:0]  memAddr,
    output logic [`SLC3_WORD-1:0]  memWData,
    output logic                   memRe,
    output logic                   memWe,
    output logic [11:0]            led,
    output logic                   halted
);

    import slc3Pkg::*;

    // ------------------------------------------------------------------
    // Controller to datapath wiring
    // ------------------------------------------------------------------
    logic [`SLC3_WORD-1:0] ir;
    logic      ben;
    logic      ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
    logic      gatePc, gateMdr, gateAlu, gateMarMux;
    logic      sr1Sel;
    logic      mioEn;
    pcSelT     pcSel;
    addr1SelT  addr1Sel;
    addr2SelT  addr2Sel;
    aluOpT     aluOp;

    // Sequencer, also drives the memory strobes
    controlUnit ctrl (.*);

    // MAR and MDR face memory directly
    datapath dp (
        .*,
        .mar (memAddr),
        .mdr (memWData)
    );

endmodule

/* test/slc3_checker.sv */
`timescale 1ns/1ps

module slc3Checker (
    input logic Clk,
    input logic rstN,
    input logic memRe,
    input logic memWe,
    input logic gatePc,
    input logic gateMdr,
    input logic gateAlu,
    input logic gateMarMux,
    input logic halted
);

    // Number of assertion failures so far
    int failCount = 0;

    // ----------------------------------------------------------------------
    // Memory strobes and bus drivers
    // ----------------------------------------------------------------------
    // Read and write never in the same cycle
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN) !(memRe && memWe))
        else begin
            failCount++;
            $error("memRe and memWe high in the same cycle");
        end

    // At most one gate on the bus
    busOneHot: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({gatePc, gateMdr, gateAlu, gateMarMux}))
        else begin
            failCount++;
            $error("more than one bus gate active");
        end

    // ----------------------------------------------------------------------
    // Halt and reset behavior
    // ----------------------------------------------------------------------
    // Pause is left only through reset
    haltSticky: assert property (@(posedge Clk) disable iff (!rstN) halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped while rstN high");
        end

    // First cycle out of reset is the MAR load, no read yet
    resetQuiet: assert property (@(posedge Clk) !rstN |=> !memRe)
        else begin
            failCount++;
            $error("memRe high in the cycle after reset");
        end

endmodule

/* test/slc3Tb.sv */
`timescale 1ns/1ps
`include "slc3_defines.svh"

module slc3Tb;

    import slc3Pkg::*;

    localparam int NumRounds = 3;
    localparam int NumKinds  = 5;
    localparam int NumTests  = NumRounds * NumKinds;
    localparam int MaxInstr  = 60;
    // LDR data window and STR scratch area
    localparam int DataBase  = 'h90;
    localparam int Scratch   = 'hC0;

    logic                  Clk;
    logic                  rstN;
    logic [`SLC3_WORD-1:0] memRData = '0;
    logic [`SLC3_WORD-1:0] memAddr;
    logic [`SLC3_WORD-1:0] memWData;
    logic                  memRe;
    logic                  memWe;
    logic [11:0]           led;
    logic                  halted;

    // Program image, memory seen by the DUT, model copy
    logic [`SLC3_WORD-1:0] image [256];
    logic [`SLC3_WORD-1:0] mem   [256];
    logic [`SLC3_WORD-1:0] mMem  [256];
    // Reference model state
    logic [`SLC3_WORD-1:0] mReg  [`SLC3_NREGS];
    logic                  mN;
    logic                  mZ;
    logic                  mP;
    logic [11:0]           mLed;

    logic                  rdPend = 1'b0;
    logic [7:0]            rdAddr = '0;
    int                    seed;
    int                    pcw;
    int                    passed;
    int                    failed;
    int                    assertFails;
    string                 kindNames [NumKinds] = '{"alu", "loadLea", "branch", "jmp", "pause"};

    slc3Top DUT (.*);

    bind controlUnit slc3Checker ctrlChk (.*);
    bind slc3Top slc3Checker topChk (.*);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // ----------------------------------------------------------------------
    // Memory model
    // ----------------------------------------------------------------------
    // Read data shows up one cycle after memRe, writes land on memWe
    always @(negedge Clk) begin
        if (rdPend) begin
            memRData = mem[rdAddr];
        end
        rdPend = (memRe === 1'b1);
        rdAddr = memAddr[7:0];
        if (memWe === 1'b1) begin
            mem[memAddr[7:0]] = memWData;
        end
    end

    // ----------------------------------------------------------------------
    // Program generation
    // ----------------------------------------------------------------------
    function automatic int rnd(int n);
        return {$random(seed)} % n;
    endfunction

    // Opcode, 3-bit field, 3-bit field, low six bits
    function automatic logic [15:0] fmt3(opcodeT op, logic [2:0] a, logic [2:0] b,
                                         logic [5:0] low);
        return {op, a, b, low};
    endfunction

    // Opcode, 3-bit field, 9-bit offset
    function automatic logic [15:0] fmt9(opcodeT op, logic [2:0] a, logic [8:0] off);
        return {op, a, off};
    endfunction

    task automatic emit(logic [15:0] word);
        image[pcw] = word;
        pcw++;
    endtask

    // PC-relative, offset from the incremented PC
    task automatic emitLea(logic [2:0] dr, int target);
        int off;
        off = target - (pcw + 1);
        emit(fmt9(opLea, dr, off[8:0]));
    endtask

    // Random ADD/AND/NOT, R7 left for the store base
    task automatic emitAlu();
        logic [2:0] dr;
        logic [2:0] s1;
        logic [2:0] s2;
        logic [4:0] imm;
        dr  = 3'(rnd(7));
        s1  = 3'(rnd(8));
        s2  = 3'(rnd(8));
        imm = 5'(rnd(32));
        case (rnd(5))
            0:       emit(fmt3(opAdd, dr, s1, {3'b000, s2}));
            1:       emit(fmt3(opAdd, dr, s1, {1'b1, imm}));
            2:       emit(fmt3(opAnd, dr, s1, {3'b000, s2}));
            3:       emit(fmt3(opAnd, dr, s1, {1'b1, imm}));
            default: emit(fmt3(opNot, dr, s1, 6'h3F));
        endcase
    endtask

    // R7 <- scratch, then R0..R7 stored in order
    task automatic storeAll();
        emitLea(3'd7, Scratch);
        for (int r = 0; r < 8; r++) begin
            emit(fmt3(opStr, 3'(r), 3'd7, 6'(r)));
        end
    endtask

    task automatic buildProgram(int kind);
        int         n;
        logic [4:0] imm;
        logic [2:0] nzp;
        pcw = 0;
        for (int a = 0; a < 256; a++) begin
            image[a] = {8'(a), 8'(a) ^ 8'hA5};
        end
        case (kind)
            0: begin
                n = 12 + rnd(8);
                repeat (n) begin
                    emitAlu();
                end
                storeAll();
            end
            1: begin
                // Random words around the LDR base
                for (int a = DataBase - 32; a < DataBase + 32; a++) begin
                    image[a] = 16'($random(seed));
                end
                emitLea(3'd6, DataBase);
                repeat (10) begin
                    if (rnd(2) == 0) begin
                        emit(fmt3(opLdr, 3'(rnd(6)), 3'd6, 6'(rnd(64))));
                    end else begin
                        emit(fmt9(opLea, 3'(rnd(6)), 9'(rnd(512))));
                    end
                end
                storeAll();
            end
            2: begin
                emitLea(3'd7, Scratch);
                for (int b = 0; b < 8; b++) begin
                    imm = 5'(rnd(32));
                    nzp = 3'(rnd(8));
                    // Bump marker in R2, CC from the immediate, maybe skip the store
                    emit(fmt3(opAdd, 3'd2, 3'd2, 6'b100001));
                    emit(fmt3(opAdd, 3'd1, 3'd0, {1'b1, imm}));
                    emit(fmt9(opBr, nzp, 9'd1));
                    emit(fmt3(opStr, 3'd2, 3'd7, 6'(b)));
                end
            end
            3: begin
                n = rnd(4);
                repeat (n) begin
                    emitAlu();
                end
                emitLea(3'd7, Scratch);
                n = 1 + rnd(6);
                // LEA target, JMP, n stores that must never run
                emitLea(3'd3, pcw + 2 + n);
                emit(fmt3(opJmp, 3'd0, 3'd3, 6'd0));
                for (int i = 0; i < n; i++) begin
                    emit(fmt3(opStr, 3'd7, 3'd7, 6'(i)));
                end
                // Landing point
                emit(fmt3(opStr, 3'd7, 3'd7, 6'd16));
            end
            default: begin
                n = rnd(6);
                repeat (n) begin
                    emitAlu();
                end
            end
        endcase
        // Every program halts with a random LED field
        emit(fmt9(opPse, 3'(rnd(8)), 9'(rnd(512))));
    endtask

    // ----------------------------------------------------------------------
    // ISA reference model
    // ----------------------------------------------------------------------
    task automatic setReg(logic [2:0] dr, logic [15:0] v);
        mReg[dr] = v;
        mN = v[15];
        mZ = (v == 16'h0000);
        mP = !v[15] && (v != 16'h0000);
    endtask

    task automatic modelRun(string name, inout int nErr);
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] opB;
        logic [15:0] off9;
        logic [15:0] ea;
        logic        halt;
        int          count;
        for (int a = 0; a < 256; a++) begin
            mMem[a] = image[a];
        end
        for (int r = 0; r < `SLC3_NREGS; r++) begin
            mReg[r] = '0;
        end
        // Registers start at zero, so Z
        mN    = 1'b0;
        mZ    = 1'b1;
        mP    = 1'b0;
        mLed  = '0;
        pc    = `SLC3_RESET_PC;
        halt  = 1'b0;
        count = 0;
        while (!halt && count < MaxInstr) begin
            ir = mMem[pc[7:0]];
            pc = pc + 16'd1;
            count++;
            opB  = ir[5] ? {{11{ir[4]}}, ir[4:0]} : mReg[ir[2:0]];
            off9 = {{7{ir[8]}}, ir[8:0]};
            ea   = mReg[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
            case (ir[15:12])
                opAdd: setReg(ir[11:9], mReg[ir[8:6]] + opB);
                opAnd: setReg(ir[11:9], mReg[ir[8:6]] & opB);
                opNot: setReg(ir[11:9], ~mReg[ir[8:6]]);
                opBr: begin
                    if ((ir[11] && mN) || (ir[10] && mZ) || (ir[9] && mP)) begin
                        pc = pc + off9;
                    end
                end
                opJmp: pc = mReg[ir[8:6]];
                opLdr: setReg(ir[11:9], mMem[ea[7:0]]);
                opStr: mMem[ea[7:0]] = mReg[ir[11:9]];
                opLea: setReg(ir[11:9], pc + off9);
                opPse: begin
                    mLed = ir[11:0];
                    halt = 1'b1;
                end
                default: ;
            endcase
        end
        if (!halt) begin
            $display("%s: reference model did not reach PSE within %0d instructions",
                     name, MaxInstr);
            nErr++;
        end
    endtask

    // ----------------------------------------------------------------------
    // One test: model, reset, run to halt, compare
    // ----------------------------------------------------------------------
    task automatic runTest(string name);
        int nErr;
        nErr = 0;
        modelRun(name, nErr);
        for (int a = 0; a < 256; a++) begin
            mem[a] = image[a];
        end
        @(negedge Clk);
        rstN = 1'b0;
        repeat (3) begin
            @(negedge Clk);
        end
        rstN = 1'b1;
        if (halted !== 1'b0) begin
            $display("MISMATCH %s halted after reset expected 0 actual %b", name, halted);
            nErr++;
        end
        if (led !== 12'h000) begin
            $display("MISMATCH %s led after reset expected 000 actual %03h", name, led);
            nErr++;
        end
        // First fetch address
        while (memRe !== 1'b1) begin
            @(negedge Clk);
        end
        if (memAddr !== `SLC3_RESET_PC) begin
            $display("MISMATCH %s first fetch expected %04h actual %04h",
                     name, `SLC3_RESET_PC, memAddr);
            nErr++;
        end
        while (halted !== 1'b1) begin
            @(negedge Clk);
        end
        // LED loads on the first pause edge
        @(negedge Clk);
        if (led !== mLed) begin
            $display("MISMATCH %s led expected %03h actual %03h", name, mLed, led);
            nErr++;
        end
        for (int a = 0; a < 256; a++) begin
            if (mem[a] !== mMem[a]) begin
                $display("MISMATCH %s mem[%02h] expected %04h actual %04h",
                         name, a, mMem[a], mem[a]);
                nErr++;
            end
        end
        if (nErr == 0) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, nErr);
        end
    endtask

    initial begin
        rstN   = 1'b0;
        seed   = 15;
        passed = 0;
        failed = 0;
        for (int round = 0; round < NumRounds; round++) begin
            for (int kind = 0; kind < NumKinds; kind++) begin
                buildProgram(kind);
                runTest($sformatf("%s_%0d", kindNames[kind], round));
            end
        end
        assertFails = DUT.ctrl.ctrlChk.failCount + DUT.topChk.failCount;
        if (assertFails != 0) begin
            $display("Checker assertions failed %0d times during the run", assertFails);
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                 NumTests, passed, failed, assertFails);
        if (failed == 0 && assertFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Worst case nine cycles per instruction at 100 ns
    initial begin
        #(NumTests * MaxInstr * 9 * 100);
        $display("Timeout: the DUT did not halt within the allowed run time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
verilog/slc3Pkg.sv
verilog/regFile.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/slc3Top.sv
test/slc3_checker.sv
test/slc3Tb.sv

/* run.sh */
#!/bin/sh
# Build and run the SLC-3 testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module slc3Tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vslc3Tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
